// ==== flist.f ====
+incdir+include
hdl/snd_pkg.sv
hdl/snd_bus_decode.sv
hdl/snd_ram.sv
hdl/psg_regs.sv
hdl/psg_voices.sv
hdl/snd_top.sv
test/snd_tb.sv

// ==== hdl/psg_regs.sv ====
//####################
// tone chip registers
// index/data access, voice settings, timer and irq
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module psg_regs import snd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       a0,        // 0 index, 1 data
    input  logic [7:0] wdata,
    input  logic       we,
    input  logic       tick,      // sample strobe
    output voice_cfg_t [`SND_NVOICE-1:0] voices,
    output logic [7:0] rdata,
    output logic       int_n
);

    localparam int VW = $clog2(`SND_NVOICE);

    logic [7:0]    idx;         // register index
    logic          data_we;
    psg_reg_e      reg_sel;     // voice fields folded onto voice 0
    logic [VW-1:0] vsel;
    logic [7:0]    tmr_period;
    logic          tmr_en;
    logic          irq_en;
    logic [7:0]    tmr_cnt;
    logic          tmr_flag;
    logic          flag_clr;

    assign data_we = we && a0;
    assign vsel    = idx[VW+1:2];
    assign reg_sel = (idx < 8'(4 * `SND_NVOICE)) ? psg_reg_e'({6'd0, idx[1:0]})
                                                 : psg_reg_e'(idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx        <= '0;
            voices     <= '0;
            tmr_period <= '0;
            tmr_en     <= 1'b0;
            irq_en     <= 1'b0;
        end else if (we && !a0) begin
            idx <= wdata;
        end else if (data_we) begin
            case (reg_sel)
                REG_FREQ_LO0:   voices[vsel].freq[7:0]  <= wdata;
                REG_FREQ_HI0:   voices[vsel].freq[15:8] <= wdata;
                REG_CTRL0: begin
                    voices[vsel].vol   <= wdata[3:0];
                    voices[vsel].pan_l <= wdata[4];
                    voices[vsel].pan_r <= wdata[5];
                end
                REG_TMR_PERIOD: tmr_period <= wdata;
                REG_TMR_CTRL: begin
                    tmr_en <= wdata[0];
                    irq_en <= wdata[1];
                end
                default: ;   // holes in the map
            endcase
        end
    end

    // write 1 to bit 2 clears the flag
    assign flag_clr = data_we && (reg_sel == REG_TMR_CTRL) && wdata[2];

    // timer counts samples, flag at period then restart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tmr_cnt  <= '0;
            tmr_flag <= 1'b0;
        end else begin
            if (!tmr_en) begin
                tmr_cnt <= '0;
            end else if (tick) begin
                if (tmr_cnt + 8'd1 == tmr_period) begin
                    tmr_cnt <= '0;
                    if (!flag_clr)
                        tmr_flag <= 1'b1;
                end else begin
                    tmr_cnt <= tmr_cnt + 8'd1;
                end
            end
            if (flag_clr)
                tmr_flag <= 1'b0;
        end
    end

    assign rdata = {7'd0, tmr_flag};   // status
    assign int_n = !(tmr_flag && irq_en);

endmodule

// ==== hdl/psg_voices.sv ====
//####################
// tone chip voices
// sample divider, square wave phases, stereo mix
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module psg_voices import snd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  voice_cfg_t [`SND_NVOICE-1:0] voices,
    output logic       tick,      // to the timer
    output logic       sample,
    output audio_t     audio
);

    localparam int DIV_W = $clog2(`SND_SAMPLE_DIV);

    logic [DIV_W-1:0]   cen_cnt;
    logic               adv;          // last cen of a sample period
    logic [15:0]        phase     [`SND_NVOICE];
    logic [15:0]        phase_nxt [`SND_NVOICE];
    logic signed [15:0] sum_l;
    logic signed [15:0] sum_r;

    assign adv = cen && (cen_cnt == DIV_W'(`SND_SAMPLE_DIV - 1));

    // cen divider
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
        end else if (cen) begin
            if (adv)
                cen_cnt <= '0;
            else
                cen_cnt <= cen_cnt + DIV_W'(1);
        end
    end

    // next phases and their mix
    // max 4 * 15 * 512 fits in 16 bits
    always_comb begin : mix
        logic signed [15:0] amp;
        logic signed [15:0] contrib;
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < `SND_NVOICE; v++) begin
            phase_nxt[v] = phase[v] + voices[v].freq;
            amp     = signed'({12'd0, voices[v].vol} << `SND_AMP_SHIFT);
            contrib = phase_nxt[v][15] ? -amp : amp;   // msb high, low half
            if (voices[v].pan_l)
                sum_l = sum_l + contrib;
            if (voices[v].pan_r)
                sum_r = sum_r + contrib;
        end
    end

    // phases, audio and strobe move together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int v = 0; v < `SND_NVOICE; v++)
                phase[v] <= '0;
            audio <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= adv;
            if (adv) begin
                for (int v = 0; v < `SND_NVOICE; v++)
                    phase[v] <= phase_nxt[v];
                audio.left  <= sum_l;
                audio.right <= sum_r;
            end
        end
    end

    assign sample = tick;   // same strobe out of the board

endmodule

// ==== hdl/snd_bus_decode.sv ====
//####################
// sound cpu bus decoder
// chip selects, read mux, rom wait states,
// command ack and nmi edge flag
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module snd_bus_decode import snd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_bus_t bus,
    input  logic [7:0] latch,      // command from main cpu
    input  logic     irqn,         // main cpu write strobe, active low
    input  logic [7:0] rom_data,
    input  logic     rom_ok,
    input  logic [7:0] ram_rdata,
    input  logic [7:0] psg_rdata,
    output logic [7:0] din,
    output logic     wait_n,
    output logic     rom_cs,
    output logic     ram_we,
    output logic     psg_we,
    output logic     ack,
    output logic     nmi_n
);

    dev_sel_e sel_nxt;
    dev_sel_e sel;          // one clock behind the address
    logic     rom_ok2;      // rom_ok delayed
    logic     rom_good;
    logic     wr_done;      // held write already served
    logic     wr_go;
    logic     irqn_l;
    logic     irq_edge;
    logic     nmi_flag;

    // address decode
    always_comb begin
        sel_nxt = DEV_NONE;
        if (!bus.mreq_n) begin
            if (bus.addr[15:`SND_ROM_AW] == '0)
                sel_nxt = DEV_ROM;
            else if (bus.addr[15:11] == `SND_LATCH_MEM)
                sel_nxt = DEV_LATCH;   // e800
            else if (bus.addr[15:11] == `SND_RAM_MEM)
                sel_nxt = DEV_RAM;
        end else if (!bus.iorq_n) begin
            case (bus.addr[7:6])
                `SND_IO_PSG:   sel_nxt = DEV_PSG;
                `SND_IO_LATCH: sel_nxt = DEV_LATCH;
                default:       sel_nxt = DEV_NONE;   // pcm slot reads ff
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel     <= DEV_NONE;
            rom_ok2 <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            sel     <= sel_nxt;
            rom_ok2 <= rom_ok;
            wr_done <= !bus.wr_n && (sel != DEV_NONE);
        end
    end

    // read data, one clock after the select
    always_ff @(posedge clk) begin
        case (sel)
            DEV_ROM:   din <= rom_data;
            DEV_RAM:   din <= ram_rdata;
            DEV_PSG:   din <= psg_rdata;
            DEV_LATCH: din <= latch;
            default:   din <= 8'hff;
        endcase
    end

    // rom data good after two clocks of rom_ok
    assign rom_good = rom_ok & rom_ok2;

    // registered so it rises together with din
    always_ff @(posedge clk) begin
        if (!rst_n)
            wait_n <= 1'b1;
        else
            wait_n <= !(sel == DEV_ROM && !bus.rd_n && !rom_good);
    end

    // one shot write enables
    assign wr_go  = !bus.wr_n && !wr_done;
    assign ram_we = wr_go && (sel == DEV_RAM);
    assign psg_we = wr_go && (sel == DEV_PSG);

    assign rom_cs = sel == DEV_ROM;
    assign ack    = sel == DEV_LATCH;   // command taken

    // nmi set by irqn falling edge, cleared by latch read
    assign irq_edge = irqn_l & ~irqn;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irqn_l   <= 1'b1;
            nmi_flag <= 1'b0;
        end else begin
            irqn_l <= irqn;
            if (sel == DEV_LATCH)
                nmi_flag <= 1'b0;   // clear wins
            else if (irq_edge)
                nmi_flag <= 1'b1;
        end
    end

    assign nmi_n = ~nmi_flag;

endmodule

// ==== hdl/snd_pkg.sv ====
//####################
// sound board types
// cpu bus, device selects, tone chip registers, audio
//####################
package snd_pkg;

    // z80 style bus as seen from the sound cpu
    typedef struct packed {
        logic [15:0] addr;
        logic        mreq_n;
        logic        iorq_n;
        logic        rd_n;
        logic        wr_n;
        logic [ 7:0] dout;   // cpu write data
    } cpu_bus_t;

    // registered device selection in the decoder
    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_ROM,
        DEV_RAM,
        DEV_PSG,
        DEV_LATCH
    } dev_sel_e;

    // tone chip register indices, four per voice
    typedef enum logic [7:0] {
        REG_FREQ_LO0   = 8'd0,
        REG_FREQ_HI0   = 8'd1,
        REG_CTRL0      = 8'd2,   // [3:0] vol, [4] pan_l, [5] pan_r
        REG_FREQ_LO1   = 8'd4,
        REG_FREQ_HI1   = 8'd5,
        REG_CTRL1      = 8'd6,
        REG_FREQ_LO2   = 8'd8,
        REG_FREQ_HI2   = 8'd9,
        REG_CTRL2      = 8'd10,
        REG_FREQ_LO3   = 8'd12,
        REG_FREQ_HI3   = 8'd13,
        REG_CTRL3      = 8'd14,
        REG_TMR_PERIOD = 8'd16,
        REG_TMR_CTRL   = 8'd17   // [0] en, [1] irq en, [2] clear flag
    } psg_reg_e;

    typedef struct packed {
        logic [15:0] freq;   // phase step per sample
        logic [ 3:0] vol;
        logic        pan_l;
        logic        pan_r;
    } voice_cfg_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } audio_t;

endpackage

// ==== hdl/snd_ram.sv ====
//####################
// sound cpu work ram
// 2 KB, synchronous read
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module snd_ram (
    input  logic                   clk,
    input  logic [`SND_RAM_AW-1:0] addr,
    input  logic [7:0]             wdata,
    input  logic                   we,
    output logic [7:0]             rdata
);

    localparam int DEPTH = 2 ** `SND_RAM_AW;

    logic [7:0] mem [DEPTH];   // contents undefined at power up

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];   // old data on a write clock
    end

endmodule

// ==== hdl/snd_top.sv ====
//####################
// arcade sound board
// decoder, work ram and tone chip around an external sound cpu
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module snd_top import snd_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen_fm,
    input  cpu_bus_t               bus,
    input  logic [7:0]             latch,
    input  logic                   irqn,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    output logic [7:0]             din,
    output logic                   wait_n,
    output logic                   int_n,
    output logic                   nmi_n,
    output logic                   ack,
    output audio_t                 audio,
    output logic                   sample
);

    logic [7:0] ram_rdata;
    logic [7:0] psg_rdata;
    logic       ram_we;
    logic       psg_we;
    logic       tick;   // sample tick to the timer
    voice_cfg_t [`SND_NVOICE-1:0] voices;

    assign rom_addr = bus.addr[`SND_ROM_AW-1:0];

    snd_bus_decode u_decode (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .bus       ( bus       ),
        .latch     ( latch     ),
        .irqn      ( irqn      ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_rdata ( ram_rdata ),
        .psg_rdata ( psg_rdata ),
        .din       ( din       ),
        .wait_n    ( wait_n    ),
        .rom_cs    ( rom_cs    ),
        .ram_we    ( ram_we    ),
        .psg_we    ( psg_we    ),
        .ack       ( ack       ),
        .nmi_n     ( nmi_n     )
    );

    snd_ram u_ram (
        .clk   ( clk                          ),
        .addr  ( bus.addr[`SND_RAM_AW-1:0]    ),
        .wdata ( bus.dout                     ),
        .we    ( ram_we                       ),
        .rdata ( ram_rdata                    )
    );

    psg_regs u_regs (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .a0     ( bus.addr[0] ),   // index or data port
        .wdata  ( bus.dout    ),
        .we     ( psg_we      ),
        .tick   ( tick        ),
        .voices ( voices      ),
        .rdata  ( psg_rdata   ),
        .int_n  ( int_n       )
    );

    psg_voices u_voices (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cen    ( cen_fm ),
        .voices ( voices ),
        .tick   ( tick   ),
        .sample ( sample ),
        .audio  ( audio  )
    );

endmodule

// ==== include/snd_cfg.svh ====
//####################
// sound board configuration
// memory map, ram depth, voice count and audio scaling
//####################
`ifndef SND_CFG_SVH
`define SND_CFG_SVH

// program rom, 0000-7fff
`define SND_ROM_AW      15

// work ram, f800-ffff
`define SND_RAM_AW      11
`define SND_RAM_MEM     5'b11111   // addr[15:11] of the ram page

// command latch read page, e800-efff
`define SND_LATCH_MEM   5'b11101   // addr[15:11]

// i/o slots, addr[7:6]
`define SND_IO_PSG      2'd0
`define SND_IO_LATCH    2'd3       // slot 2 is the unmapped pcm chip

// tone chip
`define SND_NVOICE      4
`define SND_SAMPLE_DIV  32         // cen pulses per sample
`define SND_AMP_SHIFT   9          // vol * 512 per voice

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sound board testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module snd_tb \
    -f flist.f \
    -o snd_sim

# a failing run ends in $fatal, which gives a non-zero exit status
./obj_dir/snd_sim

// ==== test/snd_tb.sv ====
//####################
// sound board testbench
// plays the sound cpu, models rom, ram, latch and tone chip
//####################
`timescale 1ns/1ps
`include "snd_cfg.svh"

module snd_tb import snd_pkg::*; ();

    localparam int WAIT_LIMIT   = 40;    // clocks, bus handshakes
    localparam int SAMPLE_LIMIT = 200;   // clocks, one sample is 64
    localparam cpu_bus_t IDLE_BUS = '{addr: 16'h0000, mreq_n: 1'b1, iorq_n: 1'b1,
                                      rd_n: 1'b1, wr_n: 1'b1, dout: 8'h00};

    logic clk    = 1'b0;
    logic rst_n  = 1'b0;
    logic cen_fm = 1'b0;
    logic irqn   = 1'b1;
    logic rom_ok = 1'b0;
    logic [7:0] latch    = 8'h00;
    logic [7:0] rom_data = 8'h00;
    cpu_bus_t   bus      = IDLE_BUS;

    logic [`SND_ROM_AW-1:0] rom_addr;
    logic       rom_cs;
    logic [7:0] din;
    logic       wait_n;
    logic       int_n;
    logic       nmi_n;
    logic       ack;
    audio_t     audio;
    logic       sample;

    int seed      = 32'h419d_0776;
    int rom_delay = 0;   // clocks from select to rom_ok
    int rom_cnt   = 0;

    // reference state
    logic [7:0]             ram_model [2 ** `SND_RAM_AW];
    logic [`SND_RAM_AW-1:0] ram_used [$];
    logic [15:0] m_freq  [`SND_NVOICE] = '{default: '0};
    logic [15:0] m_phase [`SND_NVOICE] = '{default: '0};
    logic [3:0]  m_vol   [`SND_NVOICE] = '{default: '0};
    logic        m_pan_l [`SND_NVOICE] = '{default: '0};
    logic        m_pan_r [`SND_NVOICE] = '{default: '0};

    snd_top snd_top_inst (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen_fm   ( cen_fm   ),
        .bus      ( bus      ),
        .latch    ( latch    ),
        .irqn     ( irqn     ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .din      ( din      ),
        .wait_n   ( wait_n   ),
        .int_n    ( int_n    ),
        .nmi_n    ( nmi_n    ),
        .ack      ( ack      ),
        .audio    ( audio    ),
        .sample   ( sample   )
    );

    always #50 clk = ~clk;   // 100 ns

    always @(posedge clk) cen_fm <= rst_n ? ~cen_fm : 1'b0;   // every other clock

    // rom contents, mixes every address bit
    function automatic logic [7:0] rom_func(input logic [`SND_ROM_AW-1:0] a);
        return a[7:0] ^ {1'b1, a[14:8]} ^ 8'h3c;
    endfunction

    // slow rom, data good rom_delay clocks after select
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_cnt  <= 0;
            rom_data <= ~rom_func(rom_addr);   // junk until ready
        end else if (rom_cnt >= rom_delay) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_func(rom_addr);
        end else begin
            rom_cnt <= rom_cnt + 1;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // strobes high, at least one idle clock seen by the decoder
    task automatic bus_idle();
        cpu_bus_t c;
        c        = bus;
        c.mreq_n = 1'b1;
        c.iorq_n = 1'b1;
        c.rd_n   = 1'b1;
        c.wr_n   = 1'b1;
        @(posedge clk);
        bus <= c;
        @(posedge clk);
    endtask

    task automatic bus_write(input logic io, input logic [15:0] a, input logic [7:0] d);
        cpu_bus_t c;
        c = '{addr: a, mreq_n: io, iorq_n: !io, rd_n: 1'b1, wr_n: 1'b0, dout: d};
        @(posedge clk);
        bus <= c;
        repeat (2) @(posedge clk);   // lands on the second edge
        bus_idle();
    endtask

    // read cycle, din taken once wait_n is high
    task automatic bus_read(input logic io, input logic [15:0] a,
                            output logic [7:0] d, output logic ack_seen);
        cpu_bus_t c;
        int       n;
        c = '{addr: a, mreq_n: io, iorq_n: !io, rd_n: 1'b0, wr_n: 1'b1, dout: 8'h00};
        n = 0;
        @(posedge clk);
        bus <= c;
        repeat (2) @(posedge clk);   // select, then data
        @(negedge clk);
        while (!wait_n) begin
            if (n == WAIT_LIMIT)
                report_timeout("wait_n to return high on a read");
            n++;
            @(negedge clk);
        end
        d        = din;
        ack_seen = ack;
        bus_idle();
    endtask

    // index write then data write
    task automatic write_reg(input logic [7:0] idx, input logic [7:0] val);
        bus_write(1'b1, 16'h0000, idx);
        bus_write(1'b1, 16'h0001, val);
    endtask

    task automatic wait_sample();
        int n;
        n = 0;
        @(negedge clk);
        while (!sample) begin
            if (n == SAMPLE_LIMIT)
                report_timeout("a sample pulse");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic pulse_irqn();
        int n;
        n = 0;
        @(posedge clk);
        irqn <= 1'b0;
        @(posedge clk);
        irqn <= 1'b1;
        @(negedge clk);
        while (nmi_n) begin
            if (n == WAIT_LIMIT)
                report_timeout("nmi_n to go low after the irqn pulse");
            n++;
            @(negedge clk);
        end
    endtask

    // step the voice model at a sample and compare both channels
    task automatic check_audio_sample();
        int                 sum_l;
        int                 sum_r;
        int                 amp;
        logic signed [15:0] exp_l;
        logic signed [15:0] exp_r;
        wait_sample();
        sum_l = 0;
        sum_r = 0;
        for (int v = 0; v < `SND_NVOICE; v++) begin
            m_phase[v] = m_phase[v] + m_freq[v];
            amp        = int'(m_vol[v]) * 512;
            if (m_phase[v][15])
                amp = -amp;   // low half of the square
            if (m_pan_l[v])
                sum_l += amp;
            if (m_pan_r[v])
                sum_r += amp;
        end
        exp_l = 16'(sum_l);
        exp_r = 16'(sum_r);
        check_val("audio left", {16'd0, exp_l}, {16'd0, audio.left});
        check_val("audio right", {16'd0, exp_r}, {16'd0, audio.right});
    endtask

    initial begin : main
        logic [31:0]            r;
        logic [31:0]            r2;
        logic [7:0]             d;
        logic                   ack_seen;
        logic [`SND_RAM_AW-1:0] ra;
        logic [`SND_ROM_AW-1:0] a15;
        int                     v;
        int                     per;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset wait_n", 32'd1, {31'd0, wait_n});
        check_val("reset nmi_n", 32'd1, {31'd0, nmi_n});
        check_val("reset int_n", 32'd1, {31'd0, int_n});
        check_val("reset ack", 32'd0, {31'd0, ack});
        check_val("reset rom_cs", 32'd0, {31'd0, rom_cs});
        check_val("reset sample", 32'd0, {31'd0, sample});
        check_val("reset audio", 32'd0, audio);

        // work ram
        repeat (24) begin
            r  = rand32();
            ra = r[10:0];
            bus_write(1'b0, {5'b11111, ra}, r[23:16]);
            ram_model[ra] = r[23:16];
            ram_used.push_back(ra);
        end
        foreach (ram_used[i]) begin
            bus_read(1'b0, {5'b11111, ram_used[i]}, d, ack_seen);
            check_val("ram readback", {24'd0, ram_model[ram_used[i]]}, {24'd0, d});
        end

        // rom with random wait states
        repeat (12) begin
            r         = rand32();
            a15       = r[14:0];
            rom_delay = int'(r[31:16] % 16'd6);
            bus_read(1'b0, {1'b0, a15}, d, ack_seen);
            check_val("rom read", {24'd0, rom_func(a15)}, {24'd0, d});
        end

        // pcm slot and an empty memory page
        repeat (4) begin
            r = rand32();
            bus_read(1'b1, {8'h00, 2'b10, r[5:0]}, d, ack_seen);
            check_val("pcm slot read", 32'h0000_00ff, {24'd0, d});
        end
        r = rand32();
        bus_read(1'b0, {3'b100, r[12:0]}, d, ack_seen);
        check_val("unmapped memory read", 32'h0000_00ff, {24'd0, d});

        // command latch, memory page first then i/o slot 3
        for (int i = 0; i < 2; i++) begin
            r = rand32();
            @(posedge clk);
            latch <= r[7:0];
            pulse_irqn();
            if (i == 0)
                bus_read(1'b0, {5'b11101, r[18:8]}, d, ack_seen);
            else
                bus_read(1'b1, {8'h00, 2'b11, r[13:8]}, d, ack_seen);
            check_val("latch read", {24'd0, r[7:0]}, {24'd0, d});
            check_val("ack during latch read", 32'd1, {31'd0, ack_seen});
            @(negedge clk);
            check_val("nmi_n after latch read", 32'd1, {31'd0, nmi_n});
            check_val("ack after latch read", 32'd0, {31'd0, ack});
        end

        // voices, one voice retuned after each sample
        check_audio_sample();
        repeat (12) begin
            r  = rand32();
            r2 = rand32();
            v  = int'(r[31:24]) % `SND_NVOICE;
            write_reg(8'(4 * v), r2[7:0]);
            write_reg(8'(4 * v + 1), r2[15:8]);
            write_reg(8'(4 * v + 2), {2'b00, r2[21:16]});   // pan_r, pan_l, vol
            m_freq[v]  = r2[15:0];
            m_vol[v]   = r2[19:16];
            m_pan_l[v] = r2[20];
            m_pan_r[v] = r2[21];
            repeat (3) check_audio_sample();
        end

        // timer, started right after a sample
        r   = rand32();
        per = 2 + int'(r[1:0]);
        wait_sample();
        write_reg(8'd16, 8'(per));
        write_reg(8'd17, 8'h03);   // run + irq
        for (int i = 1; i <= per; i++) begin
            wait_sample();
            @(negedge clk);
            check_val("timer int_n", (i == per) ? 32'd0 : 32'd1, {31'd0, int_n});
        end
        bus_read(1'b1, 16'h0001, d, ack_seen);
        check_val("timer status set", 32'd1, {31'd0, d[0]});
        write_reg(8'd17, 8'h06);   // clear, stop, irq still on
        @(negedge clk);
        check_val("int_n after clear", 32'd1, {31'd0, int_n});
        bus_read(1'b1, 16'h0001, d, ack_seen);
        check_val("timer status cleared", 32'd0, {31'd0, d[0]});

        $display("Result: PASSED");
        $finish;
    end

endmodule
